//--- cap_pkg.sv
package cap_pkg;

	// sample side of the buffer.
	parameter int SAMPLE_W  = 8;
	parameter int SAMPLE_AW = 8; // 256 samples per capture.

	// read side of the buffer.
	parameter int WORD_W  = 32;
	parameter int WORD_AW = 6; // 64 words per readout.

	typedef enum logic [1:0] {
		IDLE,
		ARMED,
		CAPTURE,
		DONE
	} cap_state_t;

	// a mask bit of zero makes that sample bit a don't care.
	typedef struct packed {
		logic [SAMPLE_W-1:0] value;
		logic [SAMPLE_W-1:0] mask;
	} trig_cfg_t;

	typedef struct packed {
		logic                en;
		logic [SAMPLE_W-1:0] data;
	} smp_t;

	// one word of the read stream.
	typedef struct packed {
		logic               valid;
		logic               last;
		logic [WORD_AW-1:0] index;
		logic [WORD_W-1:0]  data;
	} rd_beat_t;

endpackage

//--- capture_ctrl.sv
`timescale 1ns/1ps

module capture_ctrl
	import cap_pkg::*;
(
	input  logic                 wrclk,
	input  logic                 arst_n,
	input  logic                 arm,
	input  smp_t                 smp,
	input  logic                 hit,
	output cap_state_t           state,
	output logic [SAMPLE_AW-1:0] wraddr,
	output logic [SAMPLE_W-1:0]  wrdata,
	output logic                 wren,
	output logic                 done
);

	cap_state_t           state_q;
	cap_state_t           state_d;
	logic [SAMPLE_AW-1:0] wr_cnt;
	logic                 arm_ok;
	logic                 wr_go;
	logic                 wren_q;
	logic                 done_q;
	logic [SAMPLE_AW-1:0] wraddr_q;
	logic [SAMPLE_W-1:0]  wrdata_q;

	// arming is only honoured when no capture is in flight.
	assign arm_ok = arm && (state_q == IDLE || state_q == DONE);

	// the triggering sample goes to address 0, the rest follow in order.
	assign wr_go = (state_q == ARMED && hit) || (state_q == CAPTURE && smp.en);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE, DONE: begin
				if (arm)
					state_d = ARMED;
			end
			ARMED: begin
				if (hit)
					state_d = CAPTURE;
			end
			CAPTURE: begin
				if (smp.en && wr_cnt == '1)
					state_d = DONE; // this is the 256th write.
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge wrclk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
			wr_cnt  <= '0;
			wren_q  <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			wren_q  <= wr_go;
			done_q  <= (state_d == DONE); // registered so it can cross clocks cleanly.
			if (arm_ok)
				wr_cnt <= '0;
			else if (wr_go)
				wr_cnt <= wr_cnt + 1'b1;
		end
	end

	// address and data only matter while wren is high.
	always_ff @(posedge wrclk) begin
		wraddr_q <= wr_cnt;
		wrdata_q <= smp.data;
	end

	assign state  = state_q;
	assign wraddr = wraddr_q;
	assign wrdata = wrdata_q;
	assign wren   = wren_q;
	assign done   = done_q;

endmodule

//--- capture_top.sv
`timescale 1ns/1ps

module capture_top
	import cap_pkg::*;
(
	input  logic                wrclk,
	input  logic                rdclk,
	input  logic                arst_n,
	input  logic [SAMPLE_W-1:0] sample,
	input  logic                sample_en,
	input  logic                arm,
	input  trig_cfg_t           trig_cfg,
	input  logic                rd_start,
	output cap_state_t          state,
	output logic                rd_busy,
	output rd_beat_t            rd_beat
);

	smp_t                 smp;
	logic                 hit;
	logic [SAMPLE_AW-1:0] wraddr;
	logic [SAMPLE_W-1:0]  wrdata;
	logic                 wren;
	logic                 done;
	logic                 rden;
	logic [WORD_AW-1:0]   rdaddr;
	logic [WORD_W-1:0]    rddata;
	logic                 rddv;

	trigger_match i_trigger_match (
		.wrclk     (wrclk),
		.arst_n    (arst_n),
		.arm       (arm),
		.trig_cfg  (trig_cfg),
		.sample    (sample),
		.sample_en (sample_en),
		.smp       (smp),
		.hit       (hit)
	);

	capture_ctrl i_capture_ctrl (
		.wrclk  (wrclk),
		.arst_n (arst_n),
		.arm    (arm),
		.smp    (smp),
		.hit    (hit),
		.state  (state),
		.wraddr (wraddr),
		.wrdata (wrdata),
		.wren   (wren),
		.done   (done)
	);

	// bytes in, 32 bit words out, with a registered read port.
	dpram2 #(
		.DWW    (SAMPLE_W),
		.DWR    (WORD_W),
		.AWW    (SAMPLE_AW),
		.BUFIN  (0),
		.BUFOUT (1)
	) i_dpram2 (
		.wrclk  (wrclk),
		.rdclk  (rdclk),
		.wraddr (wraddr),
		.wrdata (wrdata),
		.wren   (wren),
		.rden   (rden),
		.rdaddr (rdaddr),
		.rddata (rddata),
		.rddv   (rddv)
	);

	readout_seq i_readout_seq (
		.rdclk    (rdclk),
		.arst_n   (arst_n),
		.done     (done),
		.rd_start (rd_start),
		.rddata   (rddata),
		.rddv     (rddv),
		.rden     (rden),
		.rdaddr   (rdaddr),
		.rd_busy  (rd_busy),
		.rd_beat  (rd_beat)
	);

endmodule

//--- dpram2.sv
`timescale 1ns/1ps

module dpram2 #(
	parameter int DWW    = 8,
	parameter int DWR    = 32,
	parameter int AWW    = 8,
	parameter int BUFIN  = 0,
	parameter int BUFOUT = 1,
	localparam int AWR = (DWW > DWR) ? (AWW + $clog2(DWW / DWR)) : (AWW - $clog2(DWR / DWW))
) (
	input  logic           wrclk,
	input  logic           rdclk,
	input  logic [AWW-1:0] wraddr,
	input  logic [DWW-1:0] wrdata,
	input  logic           wren,
	input  logic           rden,
	input  logic [AWR-1:0] rdaddr,
	output logic [DWR-1:0] rddata,
	output logic           rddv
);

	// each location holds the narrower of the two port widths.
	localparam int DWMIN  = (DWW < DWR) ? DWW : DWR;
	localparam int AWMEM  = (AWW > AWR) ? AWW : AWR;
	localparam int RATIO  = (DWW > DWR) ? (DWW / DWR) : (DWR / DWW);
	localparam int WRATIO = $clog2(RATIO);
	localparam int DEPTH  = 1 << AWMEM;

	logic [DWMIN-1:0] mem [0:DEPTH-1];

	logic [AWW-1:0] wr_addr_i;
	logic [DWW-1:0] wr_data_i;
	logic           wr_en_i;
	logic [AWR-1:0] rd_addr_i;
	logic           rd_en_i;
	logic [DWR-1:0] rd_word;

	// optional input stage adds one cycle on each port.
	if (BUFIN != 0) begin : g_bufin
		logic [AWW-1:0] wr_addr_q;
		logic [DWW-1:0] wr_data_q;
		logic           wr_en_q = 1'b0;
		logic [AWR-1:0] rd_addr_q;
		logic           rd_en_q = 1'b0;

		always_ff @(posedge wrclk) begin
			wr_addr_q <= wraddr;
			wr_data_q <= wrdata;
			wr_en_q   <= wren;
		end

		always_ff @(posedge rdclk) begin
			rd_addr_q <= rdaddr;
			rd_en_q   <= rden;
		end

		assign wr_addr_i = wr_addr_q;
		assign wr_data_i = wr_data_q;
		assign wr_en_i   = wr_en_q;
		assign rd_addr_i = rd_addr_q;
		assign rd_en_i   = rd_en_q;
	end else begin : g_nobufin
		assign wr_addr_i = wraddr;
		assign wr_data_i = wrdata;
		assign wr_en_i   = wren;
		assign rd_addr_i = rdaddr;
		assign rd_en_i   = rden;
	end

	// a wide write is split over consecutive locations, low bits first.
	if (DWW <= DWR) begin : g_wr_narrow
		always_ff @(posedge wrclk) begin
			if (wr_en_i)
				mem[wr_addr_i] <= wr_data_i;
		end
	end else begin : g_wr_wide
		for (genvar i = 0; i < RATIO; i++) begin : g_lane
			always_ff @(posedge wrclk) begin
				if (wr_en_i)
					mem[{wr_addr_i, WRATIO'(i)}] <= wr_data_i[i*DWMIN +: DWMIN];
			end
		end
	end

	// a wide read gathers the same lanes back.
	if (DWW >= DWR) begin : g_rd_narrow
		assign rd_word = mem[rd_addr_i];
	end else begin : g_rd_wide
		for (genvar j = 0; j < RATIO; j++) begin : g_lane
			assign rd_word[j*DWMIN +: DWMIN] = mem[{rd_addr_i, WRATIO'(j)}];
		end
	end

	if (BUFOUT != 0) begin : g_bufout
		logic [DWR-1:0] rd_data_q;
		logic           rd_dv_q = 1'b0; // valid before the first read clock.

		always_ff @(posedge rdclk) begin
			if (rd_en_i)
				rd_data_q <= rd_word;
			rd_dv_q <= rd_en_i;
		end

		assign rddata = rd_data_q;
		assign rddv   = rd_dv_q;
	end else begin : g_nobufout
		assign rddata = rd_word;
		assign rddv   = rd_en_i;
	end

endmodule

//--- readout_seq.sv
`timescale 1ns/1ps

module readout_seq
	import cap_pkg::*;
(
	input  logic               rdclk,
	input  logic               arst_n,
	input  logic               done,
	input  logic               rd_start,
	input  logic [WORD_W-1:0]  rddata,
	input  logic               rddv,
	output logic               rden,
	output logic [WORD_AW-1:0] rdaddr,
	output logic               rd_busy,
	output rd_beat_t           rd_beat
);

	logic               done_meta;
	logic               done_sync;
	logic               busy_q;
	logic               rden_q;
	logic [WORD_AW-1:0] rdaddr_q;
	logic [WORD_AW-1:0] beat_cnt;
	logic               beat_last;
	logic               start_ok;

	// done comes from the write clock domain.
	always_ff @(posedge rdclk or negedge arst_n) begin
		if (!arst_n) begin
			done_meta <= 1'b0;
			done_sync <= 1'b0;
		end else begin
			done_meta <= done;
			done_sync <= done_meta;
		end
	end

	assign start_ok  = rd_start && done_sync && !busy_q;
	assign beat_last = rddv && beat_cnt == '1;

	always_ff @(posedge rdclk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q   <= 1'b0;
			rden_q   <= 1'b0;
			rdaddr_q <= '0;
		end else begin
			if (start_ok) begin
				busy_q   <= 1'b1;
				rden_q   <= 1'b1;
				rdaddr_q <= '0;
			end else begin
				if (rden_q) begin
					if (rdaddr_q == '1)
						rden_q <= 1'b0;
					else
						rdaddr_q <= rdaddr_q + 1'b1;
				end
				if (beat_last)
					busy_q <= 1'b0; // busy covers the returning beats too.
			end
		end
	end

	// beats are numbered as they return, whatever the RAM latency is.
	always_ff @(posedge rdclk or negedge arst_n) begin
		if (!arst_n)
			beat_cnt <= '0;
		else if (rddv)
			beat_cnt <= beat_cnt + 1'b1; // wraps to 0 after the last beat.
	end

	assign rden    = rden_q;
	assign rdaddr  = rdaddr_q;
	assign rd_busy = busy_q;
	assign rd_beat = '{valid: rddv, last: beat_last, index: beat_cnt, data: rddata};

endmodule

//--- tb_capture.sv
`timescale 1ns/1ps

module tb_capture
	import cap_pkg::*;
();

	localparam int WR_PERIOD   = 100;
	localparam int RD_PERIOD   = 70;
	localparam int CAP_SAMPLES = 1 << SAMPLE_AW;
	localparam int CAP_WORDS   = 1 << WORD_AW;
	localparam int N_CAPTURES  = 2;
	localparam int N_READOUTS  = 3; // the first one is ignored by the DUT.
	// enable gaps can stretch a capture, so allow four cycles per sample.
	localparam int WDOG_NS = N_CAPTURES * (4 * CAP_SAMPLES + 64) * WR_PERIOD
		+ N_READOUTS * (2 * CAP_WORDS + 16) * RD_PERIOD;

	logic                wrclk;
	logic                rdclk;
	logic                arst_n;
	logic [SAMPLE_W-1:0] sample;
	logic                sample_en;
	logic                arm;
	trig_cfg_t           trig_cfg;
	logic                rd_start;
	cap_state_t          state;
	logic                rd_busy;
	rd_beat_t            rd_beat;

	logic [31:0]         lfsr;
	logic                seen_arm;
	logic                rd_allowed;
	int                  beats_seen;
	cap_state_t          m_state;
	trig_cfg_t           m_cfg;
	logic                m_prev;
	int                  m_cnt;
	logic [SAMPLE_W-1:0] m_bytes [CAP_SAMPLES];
	logic [WORD_W-1:0]   exp_words [CAP_WORDS];

	tb_clkgen #(.PERIOD_NS(WR_PERIOD), .RST_CYCLES(5)) i_wrclk_gen (
		.clk   (wrclk),
		.rst_n (arst_n)
	);

	tb_clkgen #(.PERIOD_NS(RD_PERIOD), .RST_CYCLES(5)) i_rdclk_gen (
		.clk   (rdclk),
		.rst_n ()
	);

	capture_top i_capture_top (
		.wrclk     (wrclk),
		.rdclk     (rdclk),
		.arst_n    (arst_n),
		.sample    (sample),
		.sample_en (sample_en),
		.arm       (arm),
		.trig_cfg  (trig_cfg),
		.rd_start  (rd_start),
		.state     (state),
		.rd_busy   (rd_busy),
		.rd_beat   (rd_beat)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic is_match(input logic [SAMPLE_W-1:0] v, input trig_cfg_t cfg);
		return (v & cfg.mask) == (cfg.value & cfg.mask);
	endfunction

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_failed(input string msg);
		stop_on_failure($sformatf("CHECK FAILED at %0t: %s", $time, msg));
	endtask

	task automatic drive_sample(input logic [SAMPLE_W-1:0] v, input logic en);
		@(negedge wrclk);
		sample    = v;
		sample_en = en;
		arm       = 1'b0;
	endtask

	task automatic pulse_arm(input trig_cfg_t cfg);
		@(negedge wrclk);
		arm       = 1'b1;
		trig_cfg  = cfg;
		sample_en = 1'b0;
		seen_arm  = 1'b1;
	endtask

	task automatic request_readout(input logic accept);
		@(negedge rdclk);
		rd_start   = 1'b1;
		rd_allowed = rd_allowed | accept;
		@(negedge rdclk);
		rd_start   = 1'b0;
	endtask

	// random data with random enable gaps until the DUT reports DONE.
	task automatic fill_capture(input logic arm_midway);
		int n;
		n = 0;
		while (state != DONE) begin
			if (arm_midway && n == 100)
				pulse_arm('{value: 8'hff, mask: 8'hff});
			else
				drive_sample(SAMPLE_W'(rand_bits(SAMPLE_W)), rand_bits(2) != 0);
			n++;
		end
		drive_sample('0, 1'b0);
	endtask

	task automatic read_capture();
		repeat (4) @(negedge rdclk); // done crosses two flops first.
		request_readout(1'b1);
		while (!rd_busy)
			@(negedge rdclk);
		while (rd_busy)
			@(negedge rdclk);
	endtask

	// reference model of trigger and capture that runs on the driven inputs.
	always @(posedge wrclk or negedge arst_n) begin
		if (!arst_n) begin
			m_state = IDLE;
			m_cfg   = '0;
			m_prev  = 1'b0;
			m_cnt   = 0;
		end else if (arm && (m_state == IDLE || m_state == DONE)) begin
			m_cfg   = trig_cfg;
			m_prev  = 1'b0;
			m_cnt   = 0;
			m_state = ARMED;
		end else if (sample_en) begin
			if (m_state == ARMED && is_match(sample, m_cfg) && !m_prev)
				m_state = CAPTURE;
			if (m_state == CAPTURE) begin
				m_bytes[m_cnt] = sample;
				m_cnt++;
				if (m_cnt == CAP_SAMPLES) begin
					m_state = DONE;
					for (int k = 0; k < CAP_WORDS; k++)
						exp_words[k] = {m_bytes[4*k+3], m_bytes[4*k+2], m_bytes[4*k+1], m_bytes[4*k]};
				end
			end
			m_prev = is_match(sample, m_cfg);
		end
	end

	always @(posedge rdclk) begin
		if (rd_start)
			beats_seen <= 0;
		else if (rd_beat.valid)
			beats_seen <= beats_seen + 1;
	end

	a_idle_until_arm: assert property (@(posedge wrclk) !seen_arm |-> state == IDLE)
		else check_failed("state left IDLE before the first arm");
	a_rd_quiet: assert property (@(posedge rdclk) !rd_allowed |-> !rd_busy && !rd_beat.valid)
		else check_failed("read side active without an accepted rd_start");
	// the DUT sees each sample one register later than the model does.
	a_done_early: assert property (@(posedge wrclk) disable iff (!arst_n)
		state == DONE |-> $past(m_state) == DONE)
		else check_failed("DONE before 256 samples were captured");
	a_done_late: assert property (@(posedge wrclk) disable iff (!arst_n)
		$rose(m_state == DONE) |=> state == DONE)
		else check_failed("DONE missing after 256 captured samples");
	a_arm_ignored: assert property (@(posedge wrclk) disable iff (!arst_n)
		state == CAPTURE && arm |=> state == CAPTURE)
		else check_failed("arm during CAPTURE changed the state");
	a_beat: assert property (@(posedge rdclk) disable iff (!arst_n)
		rd_beat.valid |-> beats_seen < CAP_WORDS && rd_beat.index == beats_seen[WORD_AW-1:0]
			&& rd_beat.last == (beats_seen == CAP_WORDS - 1)
			&& rd_beat.data == exp_words[beats_seen])
		else check_failed($sformatf("beat %0d has index %0d last %0b data %h",
			$sampled(beats_seen), $sampled(rd_beat.index), $sampled(rd_beat.last),
			$sampled(rd_beat.data)));
	a_contiguous: assert property (@(posedge rdclk) disable iff (!arst_n)
		rd_beat.valid && !rd_beat.last |=> rd_beat.valid)
		else check_failed("gap in the read stream before the last beat");
	a_beat_count: assert property (@(posedge rdclk) disable iff (!arst_n)
		$fell(rd_busy) |-> beats_seen == CAP_WORDS)
		else check_failed("readout did not deliver 64 beats");

	initial begin
		#(WDOG_NS);
		stop_on_failure("timeout: the capture or the readout never finished");
	end

	initial begin
		lfsr       = 32'hcec2_dd12;
		sample     = '0;
		sample_en  = 1'b0;
		arm        = 1'b0;
		trig_cfg   = '0;
		rd_start   = 1'b0;
		seen_arm   = 1'b0;
		rd_allowed = 1'b0;
		beats_seen = 0;
		@(posedge arst_n);
		request_readout(1'b0); // nothing captured yet, so it must be ignored.
		for (int i = 0; i < 4; i++)
			drive_sample(8'ha0 + SAMPLE_W'(i), 1'b1);
		pulse_arm('{value: 8'ha5, mask: 8'hf0});
		drive_sample(8'h5a, 1'b1);
		drive_sample(8'ha7, 1'b0); // a match without enable.
		drive_sample(8'h3a, 1'b1);
		drive_sample(8'hab, 1'b1);
		drive_sample(8'hac, 1'b1);
		fill_capture(1'b1);
		read_capture();
		// the second setting matches straight after arm, twice in a row.
		pulse_arm('{value: 8'h3c, mask: 8'h0f});
		drive_sample(8'h1c, 1'b1);
		drive_sample(8'h2c, 1'b1);
		fill_capture(1'b0);
		read_capture();
		$display("Regression passed");
		$finish;
	end

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS  = 100,
	parameter int RST_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			clk = ~clk;
		end
	end

	// reset drops just after time zero so that the flops see a falling edge.
	initial begin
		rst_n = 1'b1;
		#1;
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1; // released away from the rising edge.
	end

endmodule

//--- trigger_match.sv
`timescale 1ns/1ps

module trigger_match
	import cap_pkg::*;
(
	input  logic                wrclk,
	input  logic                arst_n,
	input  logic                arm,
	input  trig_cfg_t           trig_cfg,
	input  logic [SAMPLE_W-1:0] sample,
	input  logic                sample_en,
	output smp_t                smp,
	output logic                hit
);

	trig_cfg_t           cfg_q;
	logic                prev_match;
	logic                match;
	logic                smp_en_q;
	logic [SAMPLE_W-1:0] smp_data_q;
	logic                hit_q;

	// only bits under the mask take part in the compare.
	assign match = ((sample ^ cfg_q.value) & cfg_q.mask) == '0;

	always_ff @(posedge wrclk or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q      <= '0;
			prev_match <= 1'b0;
			smp_en_q   <= 1'b0;
			hit_q      <= 1'b0;
		end else begin
			smp_en_q <= sample_en;
			if (arm) begin
				// a sample that comes with the arm pulse belongs to the old setting.
				cfg_q      <= trig_cfg;
				prev_match <= 1'b0;
				hit_q      <= 1'b0;
			end else begin
				hit_q <= sample_en && match && !prev_match;
				if (sample_en)
					prev_match <= match; // gaps keep the last enabled result.
			end
		end
	end

	always_ff @(posedge wrclk) begin
		smp_data_q <= sample;
	end

	assign smp = '{en: smp_en_q, data: smp_data_q};
	assign hit = hit_q;

endmodule

//--- vlog.f
cap_pkg.sv
dpram2.sv
trigger_match.sv
capture_ctrl.sv
readout_seq.sv
capture_top.sv
tb_clkgen.sv
tb_capture.sv
